// File: cdb_settings.svh
`ifndef CDB_SETTINGS_SVH
`define CDB_SETTINGS_SVH

// functional units that compete for the bus
`define NUM_FU_ALU  3
`define NUM_FU_MULT 2
`define NUM_FU_LOAD 1
`define NUM_FU_ALL  (`NUM_FU_ALU + `NUM_FU_MULT + `NUM_FU_LOAD)

// broadcast slots per cycle
`define CDB_SZ 2

// register and reorder buffer indexing
`define PRN_WIDTH     6
`define ROB_CNT_WIDTH 5

`define XLEN 32 // data and address width

// multiplier latency in cycles
`define MULT_STAGES 3

`endif

// File: cdb_pkg.sv
`include "cdb_settings.svh"

package cdb_pkg;

    typedef logic [`PRN_WIDTH-1:0]     prn_t;
    typedef logic [`ROB_CNT_WIDTH-1:0] robn_t;
    typedef logic [`XLEN-1:0]          data_t;
    typedef logic [`XLEN-1:0]          addr_t;

    // tag and value seen by the register file
    // an all zero packet means nothing is broadcast
    typedef struct packed {
        prn_t  dest_prn;
        data_t value;
    } cdb_packet_t;

    // completion record for the reorder buffer
    typedef struct packed {
        robn_t robn;
        logic  executed;
        logic  branch_taken;
        addr_t target;
    } fu_rob_packet_t;

    // taken branch info for the predictor
    typedef struct packed {
        logic  valid_taken;
        addr_t pc;
        addr_t target;
    } predictor_packet_t;

    // finished mult or load result
    typedef struct packed {
        robn_t robn;
        prn_t  dest_prn;
        data_t result;
    } fu_result_t;

endpackage

// File: psel_gen.sv
`timescale 1ns/1ps
`include "cdb_settings.svh"

module psel_gen #(
    parameter int WIDTH = `NUM_FU_ALL,
    parameter int REQS  = `CDB_SZ
) (
    input  logic [WIDTH-1:0]           req,
    output logic [WIDTH-1:0]           gnt,
    output logic [REQS-1:0][WIDTH-1:0] gnt_bus,
    output logic                       empty
);

    logic [WIDTH-1:0] pending; // requests not claimed by an earlier slot

    // each slot takes the highest request still pending
    always_comb begin
        pending = req;
        for (int s = 0; s < REQS; s++) begin
            gnt_bus[s] = '0;
            for (int i = WIDTH - 1; i >= 0; i--) begin
                if (pending[i] && (gnt_bus[s] == '0)) begin
                    gnt_bus[s][i] = 1'b1;
                end
            end
            pending = pending & ~gnt_bus[s]; // drop the winner
        end
    end

    // union of all slot grants
    always_comb begin
        gnt = '0;
        for (int s = 0; s < REQS; s++) begin
            gnt = gnt | gnt_bus[s];
        end
    end

    assign empty = ~|req;

    // a slot drives at most one unit onto the bus
    always_comb begin
        for (int s = 0; s < REQS; s++) begin
            assert ($onehot0(gnt_bus[s]))
            else $error("psel_gen: slot %0d grant bus not one-hot %b", s, gnt_bus[s]);
        end
    end

endmodule

// File: cdb_mux.sv
`timescale 1ns/1ps
`include "cdb_settings.svh"

module cdb_mux #(
    parameter type payload_t = logic,
    parameter int  N         = `NUM_FU_ALL
) (
    input  payload_t [N-1:0] items,
    input  logic     [N-1:0] select,
    output payload_t         out
);

    localparam int PW = $bits(payload_t);

    logic [PW-1:0] acc;

    // and-or tree, zero when nothing is selected
    always_comb begin
        acc = '0;
        for (int i = 0; i < N; i++) begin
            acc = acc | (items[i] & {PW{select[i]}});
        end
    end

    assign out = payload_t'(acc);

    // overlapping selects would merge two packets
    always_comb begin
        assert ($onehot0(select))
        else $error("cdb_mux: select not one-hot %b", select);
    end

endmodule

// File: mult_fu.sv
`timescale 1ns/1ps
`include "cdb_settings.svh"

module mult_fu (
    input  logic                clock,
    input  logic                reset,
    input  logic                start,
    input  cdb_pkg::data_t      a,
    input  cdb_pkg::data_t      b,
    input  cdb_pkg::prn_t       dest_prn,
    input  cdb_pkg::robn_t      robn,
    input  logic                avail,
    output logic                ready,
    output logic                valid,
    output cdb_pkg::fu_result_t result
);

    localparam int LAST = `MULT_STAGES - 1;

    // per stage tags, operands travel until the last stage
    logic             [LAST:0]   stage_valid;
    cdb_pkg::prn_t    [LAST:0]   stage_prn;
    cdb_pkg::robn_t   [LAST:0]   stage_robn;
    cdb_pkg::data_t   [LAST-1:0] stage_a;
    cdb_pkg::data_t   [LAST-1:0] stage_b;
    cdb_pkg::data_t              product_q;  // last stage payload
    cdb_pkg::data_t              low_product;
    logic                        advance;

    // hold the whole chain while the finished result waits for the bus
    assign advance = !(stage_valid[LAST] && !avail);
    assign ready   = advance;

    assign low_product = stage_a[LAST-1] * stage_b[LAST-1]; // low XLEN bits only

    always_ff @(posedge clock) begin
        if (reset) begin
            stage_valid <= '0;
        end else if (advance) begin
            stage_valid <= {stage_valid[LAST-1:0], start};
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            stage_a[0]    <= a;
            stage_b[0]    <= b;
            stage_prn[0]  <= dest_prn;
            stage_robn[0] <= robn;
            for (int i = 1; i < LAST; i++) begin
                stage_a[i] <= stage_a[i-1];
                stage_b[i] <= stage_b[i-1];
            end
            for (int i = 1; i <= LAST; i++) begin
                stage_prn[i]  <= stage_prn[i-1];
                stage_robn[i] <= stage_robn[i-1];
            end
            product_q <= low_product;
        end
    end

    assign valid = stage_valid[LAST];

    always_comb begin
        result.robn     = stage_robn[LAST];
        result.dest_prn = stage_prn[LAST];
        result.result   = product_q;
    end

    // a blocked result must survive until the arbiter takes it
    result_held: assert property (
        @(posedge clock) disable iff (reset)
        (valid && !avail) |=> (valid && $stable(result))
    ) else $error("mult_fu: result changed while waiting for the bus");

endmodule

// File: cdb.sv
`timescale 1ns/1ps
`include "cdb_settings.svh"

module cdb (
    input  logic                                     clock,
    input  logic                                     reset,

    input  logic                   [`NUM_FU_ALU-1:0] alu_valid,
    input  logic                   [`NUM_FU_ALU-1:0] alu_cond_branch,
    input  logic                   [`NUM_FU_ALU-1:0] alu_take_branch,
    input  cdb_pkg::prn_t          [`NUM_FU_ALU-1:0] alu_dest_prn,
    input  cdb_pkg::robn_t         [`NUM_FU_ALU-1:0] alu_robn,
    input  cdb_pkg::data_t         [`NUM_FU_ALU-1:0] alu_result,
    input  cdb_pkg::addr_t         [`NUM_FU_ALU-1:0] alu_pc,

    input  logic                  [`NUM_FU_MULT-1:0] mult_valid,
    input  cdb_pkg::fu_result_t   [`NUM_FU_MULT-1:0] mult_result,
    input  logic                  [`NUM_FU_LOAD-1:0] load_valid,
    input  cdb_pkg::fu_result_t   [`NUM_FU_LOAD-1:0] load_result,

    // back to the units, high means the result may be replaced
    output logic                   [`NUM_FU_ALU-1:0] alu_avail,
    output logic                  [`NUM_FU_MULT-1:0] mult_avail,
    output logic                  [`NUM_FU_LOAD-1:0] load_avail,

    output logic                   [`NUM_FU_ALU-1:0] pred_taken,
    output cdb_pkg::addr_t         [`NUM_FU_ALU-1:0] pred_pc,
    output cdb_pkg::addr_t         [`NUM_FU_ALU-1:0] pred_target,

    output cdb_pkg::cdb_packet_t       [`CDB_SZ-1:0] cdb_packet,
    output cdb_pkg::fu_rob_packet_t    [`CDB_SZ-1:0] rob_packet
);

    // request bit layout, load lowest and alus highest
    localparam int LOAD_BASE = 0;
    localparam int MULT_BASE = `NUM_FU_LOAD;
    localparam int ALU_BASE  = `NUM_FU_LOAD + `NUM_FU_MULT;
    localparam int NUM_OTHER = `NUM_FU_LOAD + `NUM_FU_MULT;

    logic                    [`NUM_FU_ALL-1:0] req;
    logic                    [`NUM_FU_ALL-1:0] gnt;
    logic       [`CDB_SZ-1:0][`NUM_FU_ALL-1:0] gnt_bus;
    logic                                      sel_empty;

    logic                      [NUM_OTHER-1:0] other_valid;
    cdb_pkg::fu_result_t       [NUM_OTHER-1:0] other_result;

    cdb_pkg::cdb_packet_t      [`NUM_FU_ALL-1:0] cand_cdb;
    cdb_pkg::fu_rob_packet_t   [`NUM_FU_ALL-1:0] cand_rob;
    cdb_pkg::cdb_packet_t          [`CDB_SZ-1:0] slot_cdb;
    cdb_pkg::fu_rob_packet_t       [`CDB_SZ-1:0] slot_rob;
    cdb_pkg::predictor_packet_t [`NUM_FU_ALU-1:0] pred_packet;

    // conditional branches leave through the predictor only
    assign req = {alu_valid & ~alu_cond_branch, mult_valid, load_valid};

    psel_gen #(
        .WIDTH (`NUM_FU_ALL),
        .REQS  (`CDB_SZ)
    ) psel_i (
        .req     (req),
        .gnt     (gnt),
        .gnt_bus (gnt_bus),
        .empty   (sel_empty)
    );

    assign alu_avail  = gnt[ALU_BASE +: `NUM_FU_ALU] | ~alu_valid | alu_cond_branch;
    assign mult_avail = gnt[MULT_BASE +: `NUM_FU_MULT] | ~mult_valid;
    assign load_avail = gnt[LOAD_BASE +: `NUM_FU_LOAD] | ~load_valid;

    // mult and load share one layout, load sits at the bottom
    assign other_valid  = {mult_valid, load_valid};
    assign other_result = {mult_result, load_result};

    always_comb begin
        cand_cdb = '0;
        cand_rob = '0;
        for (int i = 0; i < NUM_OTHER; i++) begin
            if (other_valid[i]) begin
                cand_cdb[LOAD_BASE+i].dest_prn     = other_result[i].dest_prn;
                cand_cdb[LOAD_BASE+i].value        = other_result[i].result;
                cand_rob[LOAD_BASE+i].robn         = other_result[i].robn;
                cand_rob[LOAD_BASE+i].executed     = 1'b1;
                cand_rob[LOAD_BASE+i].branch_taken = 1'b0; // never a branch
                cand_rob[LOAD_BASE+i].target       = '0;
            end
        end
        for (int i = 0; i < `NUM_FU_ALU; i++) begin
            if (alu_valid[i]) begin
                cand_cdb[ALU_BASE+i].dest_prn     = alu_dest_prn[i];
                cand_cdb[ALU_BASE+i].value        = alu_result[i];
                cand_rob[ALU_BASE+i].robn         = alu_robn[i];
                cand_rob[ALU_BASE+i].executed     = 1'b1;
                cand_rob[ALU_BASE+i].branch_taken = alu_take_branch[i];
                cand_rob[ALU_BASE+i].target       = alu_result[i]; // jump target
            end
        end
    end

    for (genvar s = 0; s < `CDB_SZ; s++) begin : g_slot
        cdb_mux #(
            .payload_t (cdb_pkg::cdb_packet_t),
            .N         (`NUM_FU_ALL)
        ) cdb_mux_i (
            .items  (cand_cdb),
            .select (gnt_bus[s]),
            .out    (slot_cdb[s])
        );

        cdb_mux #(
            .payload_t (cdb_pkg::fu_rob_packet_t),
            .N         (`NUM_FU_ALL)
        ) rob_mux_i (
            .items  (cand_rob),
            .select (gnt_bus[s]),
            .out    (slot_rob[s])
        );

        // a grant shows up as a completion one cycle later
        grant_completes: assert property (
            @(posedge clock) disable iff (reset)
            (gnt_bus[s] != '0) |=> rob_packet[s].executed
        ) else $error("cdb: slot %0d granted but not marked executed", s);
    end

    // predictor view does not depend on arbitration
    always_comb begin
        for (int i = 0; i < `NUM_FU_ALU; i++) begin
            pred_packet[i].valid_taken = alu_valid[i] & alu_take_branch[i];
            pred_packet[i].pc          = alu_pc[i];
            pred_packet[i].target      = alu_result[i];
            pred_taken[i]  = pred_packet[i].valid_taken;
            pred_pc[i]     = pred_packet[i].pc;
            pred_target[i] = pred_packet[i].target;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            cdb_packet <= '0;
            rob_packet <= '0;
        end else begin
            cdb_packet <= slot_cdb;
            rob_packet <= slot_rob;
        end
    end

    idle_bus_quiet: assert property (
        @(posedge clock) disable iff (reset)
        sel_empty |=> (cdb_packet == '0)
    ) else $error("cdb: bus not quiet after a cycle without requests");

endmodule

// File: complete_stage.sv
`timescale 1ns/1ps
`include "cdb_settings.svh"

module complete_stage (
    input  logic                                  clock,
    input  logic                                  reset,

    input  logic                [`NUM_FU_ALU-1:0] alu_valid,
    input  logic                [`NUM_FU_ALU-1:0] alu_cond_branch,
    input  logic                [`NUM_FU_ALU-1:0] alu_take_branch,
    input  cdb_pkg::prn_t       [`NUM_FU_ALU-1:0] alu_dest_prn,
    input  cdb_pkg::robn_t      [`NUM_FU_ALU-1:0] alu_robn,
    input  cdb_pkg::data_t      [`NUM_FU_ALU-1:0] alu_result,
    input  cdb_pkg::addr_t      [`NUM_FU_ALU-1:0] alu_pc,

    input  logic               [`NUM_FU_LOAD-1:0] load_valid,
    input  cdb_pkg::prn_t      [`NUM_FU_LOAD-1:0] load_dest_prn,
    input  cdb_pkg::robn_t     [`NUM_FU_LOAD-1:0] load_robn,
    input  cdb_pkg::data_t     [`NUM_FU_LOAD-1:0] load_result,

    input  logic               [`NUM_FU_MULT-1:0] mult_start,
    input  cdb_pkg::data_t     [`NUM_FU_MULT-1:0] mult_a,
    input  cdb_pkg::data_t     [`NUM_FU_MULT-1:0] mult_b,
    input  cdb_pkg::prn_t      [`NUM_FU_MULT-1:0] mult_dest_prn,
    input  cdb_pkg::robn_t     [`NUM_FU_MULT-1:0] mult_robn,
    output logic               [`NUM_FU_MULT-1:0] mult_ready,

    output logic                [`NUM_FU_ALU-1:0] alu_avail,
    output logic               [`NUM_FU_LOAD-1:0] load_avail,

    output cdb_pkg::prn_t           [`CDB_SZ-1:0] cdb_dest_prn,
    output cdb_pkg::data_t          [`CDB_SZ-1:0] cdb_value,
    output cdb_pkg::robn_t          [`CDB_SZ-1:0] rob_robn,
    output logic                    [`CDB_SZ-1:0] rob_executed,
    output logic                    [`CDB_SZ-1:0] rob_branch_taken,
    output cdb_pkg::addr_t          [`CDB_SZ-1:0] rob_target,

    output logic                [`NUM_FU_ALU-1:0] pred_taken,
    output cdb_pkg::addr_t      [`NUM_FU_ALU-1:0] pred_pc,
    output cdb_pkg::addr_t      [`NUM_FU_ALU-1:0] pred_target
);

    logic                       [`NUM_FU_MULT-1:0] mult_valid;
    logic                       [`NUM_FU_MULT-1:0] mult_avail;
    cdb_pkg::fu_result_t        [`NUM_FU_MULT-1:0] mult_result;
    cdb_pkg::fu_result_t        [`NUM_FU_LOAD-1:0] load_packed;
    cdb_pkg::cdb_packet_t            [`CDB_SZ-1:0] cdb_packet;
    cdb_pkg::fu_rob_packet_t         [`CDB_SZ-1:0] rob_packet;

    for (genvar m = 0; m < `NUM_FU_MULT; m++) begin : g_mult
        mult_fu mult_fu_i (
            .clock    (clock),
            .reset    (reset),
            .start    (mult_start[m]),
            .a        (mult_a[m]),
            .b        (mult_b[m]),
            .dest_prn (mult_dest_prn[m]),
            .robn     (mult_robn[m]),
            .avail    (mult_avail[m]),   // freezes the pipe when low
            .ready    (mult_ready[m]),
            .valid    (mult_valid[m]),
            .result   (mult_result[m])
        );
    end

    always_comb begin
        for (int i = 0; i < `NUM_FU_LOAD; i++) begin
            load_packed[i].robn     = load_robn[i];
            load_packed[i].dest_prn = load_dest_prn[i];
            load_packed[i].result   = load_result[i];
        end
    end

    cdb cdb_i (
        .clock           (clock),
        .reset           (reset),
        .alu_valid       (alu_valid),
        .alu_cond_branch (alu_cond_branch),
        .alu_take_branch (alu_take_branch),
        .alu_dest_prn    (alu_dest_prn),
        .alu_robn        (alu_robn),
        .alu_result      (alu_result),
        .alu_pc          (alu_pc),
        .mult_valid      (mult_valid),
        .mult_result     (mult_result),
        .load_valid      (load_valid),
        .load_result     (load_packed),
        .alu_avail       (alu_avail),
        .mult_avail      (mult_avail),
        .load_avail      (load_avail),
        .pred_taken      (pred_taken),
        .pred_pc         (pred_pc),
        .pred_target     (pred_target),
        .cdb_packet      (cdb_packet),
        .rob_packet      (rob_packet)
    );

    // split the registered slot packets into loose ports
    always_comb begin
        for (int s = 0; s < `CDB_SZ; s++) begin
            cdb_dest_prn[s]     = cdb_packet[s].dest_prn;
            cdb_value[s]        = cdb_packet[s].value;
            rob_robn[s]         = rob_packet[s].robn;
            rob_executed[s]     = rob_packet[s].executed;
            rob_branch_taken[s] = rob_packet[s].branch_taken;
            rob_target[s]       = rob_packet[s].target;
        end
    end

endmodule

// File: complete_stage_tb_table.svh
// unit codes in request bit order
localparam int W_LD   = 0;
localparam int W_M0   = 1;
localparam int W_M1   = 2;
localparam int W_A0   = 3;
localparam int W_A1   = 4;
localparam int W_A2   = 5;
localparam int W_NONE = 7; // slot left empty

localparam int MULT_BIT       = `NUM_FU_LOAD;
localparam int ALU_BIT        = `NUM_FU_LOAD + `NUM_FU_MULT;
localparam int LAST           = `MULT_STAGES - 1;
localparam int MULT_ROBN_BASE = 16; // mult tags live in the upper half

typedef struct packed {
    logic [`NUM_FU_ALU-1:0]  alu_v;
    logic [`NUM_FU_ALU-1:0]  cond;
    logic [`NUM_FU_ALU-1:0]  take;
    logic                    load_v;
    logic [`NUM_FU_MULT-1:0] start;
    logic [`CDB_SZ-1:0][2:0] win;
} row_t;

row_t rows[$];

// scoreboard state
logic [`NUM_FU_ALU-1:0]  alu_pend;
logic [`NUM_FU_LOAD-1:0] load_pend;
logic                    m_valid [`NUM_FU_MULT][`MULT_STAGES];
cdb_pkg::data_t          m_a     [`NUM_FU_MULT][`MULT_STAGES];
cdb_pkg::data_t          m_b     [`NUM_FU_MULT][`MULT_STAGES];
cdb_pkg::prn_t           m_prn   [`NUM_FU_MULT][`MULT_STAGES];
cdb_pkg::robn_t          m_robn  [`NUM_FU_MULT][`MULT_STAGES];
cdb_pkg::robn_t          next_mult_robn;
int                      model_win [`CDB_SZ];
int                      accept_cnt [32];
int                      bcast_cnt [32];

// expected outputs
logic [`NUM_FU_ALU-1:0]  exp_alu_avail;
logic [`NUM_FU_LOAD-1:0] exp_load_avail;
logic [`NUM_FU_MULT-1:0] exp_mult_ready;
cdb_pkg::prn_t           exp_prn    [`CDB_SZ];
cdb_pkg::data_t          exp_value  [`CDB_SZ];
cdb_pkg::robn_t          exp_robn   [`CDB_SZ];
logic                    exp_exec   [`CDB_SZ];
logic                    exp_taken  [`CDB_SZ];
cdb_pkg::addr_t          exp_target [`CDB_SZ];

task automatic add_row(input logic [2:0] av, input logic [2:0] cd, input logic [2:0] tk,
                       input logic ld, input logic [1:0] ms, input int w0, input int w1);
    row_t row;
    row.alu_v  = av;
    row.cond   = cd;
    row.take   = tk;
    row.load_v = ld;
    row.start  = ms;
    row.win[0] = 3'(w0);
    row.win[1] = 3'(w1);
    rows.push_back(row);
endtask

task automatic build_table();
    add_row(3'b000, 3'b000, 3'b000, 1'b0, 2'b00, W_NONE, W_NONE); // idle after reset
    add_row(3'b000, 3'b000, 3'b000, 1'b0, 2'b11, W_NONE, W_NONE);
    add_row(3'b000, 3'b000, 3'b000, 1'b0, 2'b01, W_NONE, W_NONE);
    add_row(3'b111, 3'b000, 3'b000, 1'b1, 2'b00, W_A2, W_A1);
    add_row(3'b111, 3'b000, 3'b000, 1'b1, 2'b00, W_A2, W_A1); // all six request
    add_row(3'b111, 3'b000, 3'b000, 1'b0, 2'b10, W_A2, W_A1); // mult1 start refused
    add_row(3'b011, 3'b000, 3'b000, 1'b0, 2'b00, W_A1, W_A0);
    add_row(3'b000, 3'b000, 3'b000, 1'b0, 2'b00, W_M1, W_M0);
    add_row(3'b000, 3'b000, 3'b000, 1'b0, 2'b00, W_M0, W_LD);
    add_row(3'b111, 3'b101, 3'b110, 1'b0, 2'b00, W_A1, W_NONE); // branches
    add_row(3'b000, 3'b000, 3'b000, 1'b0, 2'b11, W_NONE, W_NONE);
    add_row(3'b000, 3'b000, 3'b000, 1'b0, 2'b11, W_NONE, W_NONE);
    add_row(3'b000, 3'b000, 3'b000, 1'b1, 2'b00, W_LD, W_NONE);
    add_row(3'b000, 3'b000, 3'b000, 1'b0, 2'b00, W_M1, W_M0);
    add_row(3'b000, 3'b000, 3'b000, 1'b0, 2'b00, W_M1, W_M0); // back to back
    add_row(3'b100, 3'b000, 3'b100, 1'b0, 2'b01, W_A2, W_NONE);
    add_row(3'b110, 3'b000, 3'b000, 1'b0, 2'b00, W_A2, W_A1);
    add_row(3'b111, 3'b000, 3'b000, 1'b0, 2'b00, W_A2, W_A1);
    add_row(3'b111, 3'b000, 3'b000, 1'b0, 2'b00, W_A2, W_A1); // mult0 blocked
    add_row(3'b000, 3'b000, 3'b000, 1'b0, 2'b00, W_A0, W_M0);
    add_row(3'b000, 3'b000, 3'b000, 1'b0, 2'b00, W_NONE, W_NONE);
    add_row(3'b000, 3'b000, 3'b000, 1'b0, 2'b00, W_NONE, W_NONE);
endtask

task automatic reset_model();
    alu_pend       = '0;
    load_pend      = '0;
    next_mult_robn = cdb_pkg::robn_t'(MULT_ROBN_BASE);
    for (int m = 0; m < `NUM_FU_MULT; m++) begin
        for (int st = 0; st < `MULT_STAGES; st++) begin
            m_valid[m][st] = 1'b0;
        end
    end
    for (int n = 0; n < 32; n++) begin
        accept_cnt[n] = 0;
        bcast_cnt[n]  = 0;
    end
    for (int s = 0; s < `CDB_SZ; s++) begin
        expect_slot(s, W_NONE); // bus is quiet out of reset
    end
endtask

task automatic expect_slot(input int s, input int unit);
    int k;
    exp_prn[s]    = '0;
    exp_value[s]  = '0;
    exp_robn[s]   = '0;
    exp_exec[s]   = 1'b0;
    exp_taken[s]  = 1'b0;
    exp_target[s] = '0;
    if (unit != W_NONE) begin
        exp_exec[s] = 1'b1;
        if (unit >= ALU_BIT) begin
            k = unit - ALU_BIT;
            exp_prn[s]    = alu_dest_prn[k];
            exp_value[s]  = alu_result[k];
            exp_robn[s]   = alu_robn[k];
            exp_taken[s]  = alu_take_branch[k];
            exp_target[s] = alu_result[k]; // the alu result is the jump target
        end else if (unit >= MULT_BIT) begin
            k = unit - MULT_BIT;
            exp_prn[s]   = m_prn[k][LAST];
            exp_value[s] = m_a[k][LAST] * m_b[k][LAST]; // low word only
            exp_robn[s]  = m_robn[k][LAST];
        end else begin
            exp_prn[s]   = load_dest_prn[unit];
            exp_value[s] = load_result[unit];
            exp_robn[s]  = load_robn[unit];
        end
    end
endtask

task automatic compute_model(input row_t row, input int r);
    logic [`NUM_FU_ALL-1:0] req;
    logic [`NUM_FU_ALL-1:0] granted;
    int                     slot;
    req     = '0;
    granted = '0;
    slot    = 0;
    for (int l = 0; l < `NUM_FU_LOAD; l++) begin
        req[l] = load_valid[l];
    end
    for (int m = 0; m < `NUM_FU_MULT; m++) begin
        req[MULT_BIT+m] = m_valid[m][LAST];
    end
    for (int i = 0; i < `NUM_FU_ALU; i++) begin
        req[ALU_BIT+i] = alu_valid[i] & ~alu_cond_branch[i]; // branches skip the bus
    end
    for (int s = 0; s < `CDB_SZ; s++) begin
        model_win[s] = W_NONE;
    end
    for (int b = `NUM_FU_ALL - 1; b >= 0; b--) begin
        if (req[b] && slot < `CDB_SZ) begin
            model_win[slot] = b;
            granted[b]      = 1'b1;
            slot++;
        end
    end
    for (int s = 0; s < `CDB_SZ; s++) begin
        assert (model_win[s] == int'(row.win[s]))
        else begin
            failures++;
            $display("row %0d slot %0d: table names unit %0d but the priority rule picks %0d",
                     r, s, row.win[s], model_win[s]);
        end
        expect_slot(s, model_win[s]);
    end
    exp_alu_avail  = granted[ALU_BIT +: `NUM_FU_ALU] | ~alu_valid | alu_cond_branch;
    exp_load_avail = granted[0 +: `NUM_FU_LOAD] | ~load_valid;
    for (int m = 0; m < `NUM_FU_MULT; m++) begin
        exp_mult_ready[m] = !(m_valid[m][LAST] && !granted[MULT_BIT+m]);
    end
endtask

// state after the rising edge
task automatic advance_model();
    alu_pend  = alu_valid & ~exp_alu_avail;
    load_pend = load_valid & ~exp_load_avail;
    for (int m = 0; m < `NUM_FU_MULT; m++) begin
        if (exp_mult_ready[m]) begin
            for (int st = LAST; st > 0; st--) begin
                m_valid[m][st] = m_valid[m][st-1];
                m_a[m][st]     = m_a[m][st-1];
                m_b[m][st]     = m_b[m][st-1];
                m_prn[m][st]   = m_prn[m][st-1];
                m_robn[m][st]  = m_robn[m][st-1];
            end
            m_valid[m][0] = mult_start[m];
            m_a[m][0]     = mult_a[m];
            m_b[m][0]     = mult_b[m];
            m_prn[m][0]   = mult_dest_prn[m];
            m_robn[m][0]  = mult_robn[m];
            if (mult_start[m]) begin
                accept_cnt[mult_robn[m]]++;
            end
        end
    end
endtask

task automatic check_broadcast();
    for (int s = 0; s < `CDB_SZ; s++) begin
        check_value($sformatf("cdb_dest_prn[%0d]", s), 32'(cdb_dest_prn[s]), 32'(exp_prn[s]));
        check_value($sformatf("cdb_value[%0d]", s), cdb_value[s], exp_value[s]);
        check_value($sformatf("rob_robn[%0d]", s), 32'(rob_robn[s]), 32'(exp_robn[s]));
        check_value($sformatf("rob_executed[%0d]", s), 32'(rob_executed[s]),
                    32'(exp_exec[s]));
        check_value($sformatf("rob_branch_taken[%0d]", s), 32'(rob_branch_taken[s]),
                    32'(exp_taken[s]));
        check_value($sformatf("rob_target[%0d]", s), rob_target[s], exp_target[s]);
        if (rob_executed[s] && rob_robn[s] >= 5'd16) begin
            bcast_cnt[rob_robn[s]]++;
        end
    end
endtask

// every accepted product goes out exactly once
task automatic check_counts();
    for (int n = MULT_ROBN_BASE; n < 32; n++) begin
        check_value($sformatf("broadcasts of robn %0d", n), 32'(bcast_cnt[n]),
                    32'(accept_cnt[n]));
    end
endtask

// File: complete_stage_tb.sv
`timescale 1ns/1ps
`include "cdb_settings.svh"

module complete_stage_tb;

    logic clock;
    logic reset;

    logic                [`NUM_FU_ALU-1:0] alu_valid;
    logic                [`NUM_FU_ALU-1:0] alu_cond_branch;
    logic                [`NUM_FU_ALU-1:0] alu_take_branch;
    cdb_pkg::prn_t       [`NUM_FU_ALU-1:0] alu_dest_prn;
    cdb_pkg::robn_t      [`NUM_FU_ALU-1:0] alu_robn;
    cdb_pkg::data_t      [`NUM_FU_ALU-1:0] alu_result;
    cdb_pkg::addr_t      [`NUM_FU_ALU-1:0] alu_pc;

    logic               [`NUM_FU_LOAD-1:0] load_valid;
    cdb_pkg::prn_t      [`NUM_FU_LOAD-1:0] load_dest_prn;
    cdb_pkg::robn_t     [`NUM_FU_LOAD-1:0] load_robn;
    cdb_pkg::data_t     [`NUM_FU_LOAD-1:0] load_result;

    logic               [`NUM_FU_MULT-1:0] mult_start;
    cdb_pkg::data_t     [`NUM_FU_MULT-1:0] mult_a;
    cdb_pkg::data_t     [`NUM_FU_MULT-1:0] mult_b;
    cdb_pkg::prn_t      [`NUM_FU_MULT-1:0] mult_dest_prn;
    cdb_pkg::robn_t     [`NUM_FU_MULT-1:0] mult_robn;
    logic               [`NUM_FU_MULT-1:0] mult_ready;

    logic                [`NUM_FU_ALU-1:0] alu_avail;
    logic               [`NUM_FU_LOAD-1:0] load_avail;

    cdb_pkg::prn_t           [`CDB_SZ-1:0] cdb_dest_prn;
    cdb_pkg::data_t          [`CDB_SZ-1:0] cdb_value;
    cdb_pkg::robn_t          [`CDB_SZ-1:0] rob_robn;
    logic                    [`CDB_SZ-1:0] rob_executed;
    logic                    [`CDB_SZ-1:0] rob_branch_taken;
    cdb_pkg::addr_t          [`CDB_SZ-1:0] rob_target;

    logic                [`NUM_FU_ALU-1:0] pred_taken;
    cdb_pkg::addr_t      [`NUM_FU_ALU-1:0] pred_pc;
    cdb_pkg::addr_t      [`NUM_FU_ALU-1:0] pred_target;

    int          mismatches  = 0;
    int          failures    = 0;
    int          cycles      = 0;
    int          cycle_limit = 1000; // tightened once the table length is known
    logic [31:0] lcg_state   = 32'hbe6c;

    `include "complete_stage_tb_table.svh"

    complete_stage dut_i (
        .clock            (clock),
        .reset            (reset),
        .alu_valid        (alu_valid),
        .alu_cond_branch  (alu_cond_branch),
        .alu_take_branch  (alu_take_branch),
        .alu_dest_prn     (alu_dest_prn),
        .alu_robn         (alu_robn),
        .alu_result       (alu_result),
        .alu_pc           (alu_pc),
        .load_valid       (load_valid),
        .load_dest_prn    (load_dest_prn),
        .load_robn        (load_robn),
        .load_result      (load_result),
        .mult_start       (mult_start),
        .mult_a           (mult_a),
        .mult_b           (mult_b),
        .mult_dest_prn    (mult_dest_prn),
        .mult_robn        (mult_robn),
        .mult_ready       (mult_ready),
        .alu_avail        (alu_avail),
        .load_avail       (load_avail),
        .cdb_dest_prn     (cdb_dest_prn),
        .cdb_value        (cdb_value),
        .rob_robn         (rob_robn),
        .rob_executed     (rob_executed),
        .rob_branch_taken (rob_branch_taken),
        .rob_target       (rob_target),
        .pred_taken       (pred_taken),
        .pred_pc          (pred_pc),
        .pred_target      (pred_target)
    );

    always #5 clock = ~clock;

    always @(posedge clock) begin
        if (!reset) begin
            cycles <= cycles + 1;
        end
        if (cycles > cycle_limit) begin
            $display("timeout, the run did not end within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else begin
            mismatches++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic clear_inputs();
        alu_valid       = '0;
        alu_cond_branch = '0;
        alu_take_branch = '0;
        alu_dest_prn    = '0;
        alu_robn        = '0;
        alu_result      = '0;
        alu_pc          = '0;
        load_valid      = '0;
        load_dest_prn   = '0;
        load_robn       = '0;
        load_result     = '0;
        mult_start      = '0;
        mult_a          = '0;
        mult_b          = '0;
        mult_dest_prn   = '0;
        mult_robn       = '0;
    endtask

    // a unit that lost arbitration keeps presenting the same result
    task automatic drive_row(input row_t row);
        for (int i = 0; i < `NUM_FU_ALU; i++) begin
            if (!alu_pend[i]) begin
                alu_valid[i]       = row.alu_v[i];
                alu_cond_branch[i] = row.cond[i];
                alu_take_branch[i] = row.take[i];
                alu_dest_prn[i]    = cdb_pkg::prn_t'(next_rand());
                alu_robn[i]        = cdb_pkg::robn_t'(next_rand() % 16); // below mult range
                alu_result[i]      = next_rand();
                alu_pc[i]          = next_rand();
            end
        end
        for (int l = 0; l < `NUM_FU_LOAD; l++) begin
            if (!load_pend[l]) begin
                load_valid[l]    = row.load_v;
                load_dest_prn[l] = cdb_pkg::prn_t'(next_rand());
                load_robn[l]     = cdb_pkg::robn_t'(next_rand() % 16);
                load_result[l]   = next_rand();
            end
        end
        for (int m = 0; m < `NUM_FU_MULT; m++) begin
            mult_start[m]    = row.start[m];
            mult_a[m]        = next_rand();
            mult_b[m]        = next_rand();
            mult_dest_prn[m] = cdb_pkg::prn_t'(next_rand());
            mult_robn[m]     = next_mult_robn;
            if (row.start[m]) begin
                next_mult_robn++; // a refused start burns its tag
            end
        end
    endtask

    // levels that must hold within the cycle
    task automatic check_levels();
        for (int i = 0; i < `NUM_FU_ALU; i++) begin
            check_value($sformatf("alu_avail[%0d]", i), 32'(alu_avail[i]),
                        32'(exp_alu_avail[i]));
            check_value($sformatf("pred_taken[%0d]", i), 32'(pred_taken[i]),
                        32'(alu_valid[i] & alu_take_branch[i]));
            check_value($sformatf("pred_pc[%0d]", i), pred_pc[i], alu_pc[i]);
            check_value($sformatf("pred_target[%0d]", i), pred_target[i], alu_result[i]);
        end
        for (int l = 0; l < `NUM_FU_LOAD; l++) begin
            check_value($sformatf("load_avail[%0d]", l), 32'(load_avail[l]),
                        32'(exp_load_avail[l]));
        end
        for (int m = 0; m < `NUM_FU_MULT; m++) begin
            check_value($sformatf("mult_ready[%0d]", m), 32'(mult_ready[m]),
                        32'(exp_mult_ready[m]));
        end
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        clear_inputs();
        reset_model();
        build_table();
        cycle_limit = rows.size() * (`MULT_STAGES + 4) + 50;
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        for (int r = 0; r < rows.size(); r++) begin
            check_broadcast();
            drive_row(rows[r]);
            compute_model(rows[r], r);
            #2;
            check_levels();
            advance_model();
            @(negedge clock);
        end
        check_broadcast(); // last row's slots
        check_counts();
        $display("checks done: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: complete_stage.f
+incdir+.
cdb_pkg.sv
psel_gen.sv
cdb_mux.sv
mult_fu.sv
cdb.sv
complete_stage.sv
complete_stage_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the completion stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f complete_stage.f \
    --top-module complete_stage_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vcomplete_stage_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TB PASSED"; then
    exit 0
fi
echo "simulation did not report a pass"
exit 1
